//--- common/disk_pkg.sv
package disk_pkg;

	// ==============================
	// Sector buffer and drive slots
	// ==============================
	localparam int SECTOR_BYTES = 512;
	localparam int NUM_SLOTS    = 3;

	typedef logic [$clog2(SECTOR_BYTES)-1:0] sector_addr_t;
	typedef logic [31:0]                     lba_t;
	typedef logic [31:0]                     img_size_t;
	typedef logic [NUM_SLOTS-1:0]            slot_mask_t;
	typedef logic [31:0]                     ctrl_word_t;
	typedef logic [2:0]                      drive_num_t;

	// Controller opcodes
	typedef enum logic [2:0] {
		cmd_set_lba,
		cmd_write_byte,
		cmd_read_byte,
		cmd_rewind,
		cmd_block_read,
		cmd_block_write,
		cmd_read_status,
		cmd_read_size
	} disk_cmd_e;

	typedef enum logic [1:0] {
		seq_idle,
		seq_wait_ack,
		seq_wait_release
	} seq_state_e;

	// Status word layout
	localparam int STAT_IO_DONE  = 0;
	localparam int STAT_MOUNT    = 1;
	localparam int STAT_FILE_LO  = 2;
	localparam int STAT_FILE_HI  = 4;
	localparam int STAT_TYPE_LO  = 5;
	localparam int STAT_TYPE_HI  = 6;
	localparam int STAT_READONLY = 7;

endpackage

//--- common/axis_pkg.sv
package axis_pkg;

	// Mouse packet as delivered by the host, strobe toggles per packet
	typedef struct packed {
		logic       strobe;
		logic [7:0] y_delta;
		logic [7:0] x_delta;
		logic [1:0] rsvd_hi;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] rsvd_lo;
		logic [1:0] buttons;
	} mouse_pkt_t;

	typedef logic [7:0]        axis_t;
	typedef logic signed [8:0] pos_t;

	// Step limit per packet and paddle range
	localparam int MOUSE_STEP_MAX = 10;
	localparam int AXIS_MIN       = -128;
	localparam int AXIS_MAX       = 127;

endpackage

//--- disk/disk_ctrl_regs.sv
`timescale 1ns/10ps

module disk_ctrl_regs (
	input  logic                 clk_sys,
	input  logic                 areset,
	input  logic                 cmd_valid,
	input  disk_pkg::disk_cmd_e  cmd_op,
	input  disk_pkg::drive_num_t cmd_drive,
	input  disk_pkg::ctrl_word_t cmd_data,
	output logic                 cmd_ready,
	output logic                 rd_valid,
	output disk_pkg::ctrl_word_t rd_data,
	output disk_pkg::lba_t       sd_lba,
	input  disk_pkg::slot_mask_t img_mounted,
	input  logic                 img_readonly,
	input  logic [1:0]           img_type,
	input  disk_pkg::img_size_t  img_size,
	output logic                 seq_start_rd,
	output logic                 seq_start_wr,
	output logic [1:0]           seq_slot,
	input  logic                 seq_busy,
	input  logic                 seq_done,
	output logic                 ptr_write,
	output logic                 ptr_read,
	output logic                 ptr_rewind,
	output logic [7:0]           wr_byte,
	input  logic [7:0]           rd_byte
);
	import disk_pkg::*;

	logic       accept;
	logic       is_read;
	logic       io_done;
	logic       mount_toggle;
	logic [2:0] file_no;
	logic [1:0] file_type;
	logic       read_only;
	img_size_t  file_size;
	slot_mask_t mounted_q;
	logic       any_mounted_q;
	logic       mount_rise;
	ctrl_word_t status_word;
	ctrl_word_t word_q;
	logic       byte_sel_q;

	// ==============================
	// Command decode
	// ==============================
	assign cmd_ready = ~seq_busy;
	assign accept    = cmd_valid & cmd_ready;
	assign is_read   = cmd_op inside {cmd_read_byte, cmd_read_status, cmd_read_size};

	// Drive 0, 1 and 4 land on slots 0, 1 and 2
	assign seq_slot     = {cmd_drive[2], cmd_drive[0]};
	assign seq_start_rd = accept && (cmd_op == cmd_block_read);
	assign seq_start_wr = accept && (cmd_op == cmd_block_write);
	assign ptr_write    = accept && (cmd_op == cmd_write_byte);
	assign ptr_read     = accept && (cmd_op == cmd_read_byte);
	assign ptr_rewind   = accept && (cmd_op == cmd_rewind);
	assign wr_byte      = cmd_data[7:0];

	always_ff @(posedge clk_sys) begin
		if (accept && (cmd_op == cmd_set_lba))
			sd_lba <= cmd_data;
	end

	// ==============================
	// io_done and mount tracking
	// ==============================
	assign mount_rise = (|mounted_q) & ~any_mounted_q;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			io_done       <= 1'b0;
			mount_toggle  <= 1'b0;
			mounted_q     <= '0;
			any_mounted_q <= 1'b0;
		end else begin
			mounted_q     <= img_mounted;
			any_mounted_q <= |mounted_q;
			if (seq_start_rd || seq_start_wr)
				io_done <= 1'b0;
			else if (seq_done)
				io_done <= 1'b1;
			if (mount_rise)
				mount_toggle <= ~mount_toggle;
		end
	end

	// Highest slot wins if several mount at once
	always_ff @(posedge clk_sys) begin
		if (mount_rise) begin
			if (mounted_q[0])
				file_no <= 3'd0;
			if (mounted_q[1])
				file_no <= 3'd1;
			if (mounted_q[2])
				file_no <= 3'd4;
			file_type <= img_type;
			read_only <= img_readonly | mounted_q[2];
			file_size <= img_size;
		end
	end

	always_comb begin
		status_word = '0;
		status_word[STAT_IO_DONE]              = io_done;
		status_word[STAT_MOUNT]                = mount_toggle;
		status_word[STAT_FILE_HI:STAT_FILE_LO] = file_no;
		status_word[STAT_TYPE_HI:STAT_TYPE_LO] = file_type;
		status_word[STAT_READONLY]             = read_only;
	end

	// ==============================
	// Read-back
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			rd_valid   <= 1'b0;
			byte_sel_q <= 1'b0;
		end else begin
			rd_valid   <= accept && is_read;
			byte_sel_q <= cmd_op == cmd_read_byte;
		end
	end

	// Status is captured at acceptance so it reflects that cycle
	always_ff @(posedge clk_sys) begin
		if (accept)
			word_q <= (cmd_op == cmd_read_size) ? file_size : status_word;
	end

	assign rd_data = byte_sel_q ? ctrl_word_t'(rd_byte) : word_q;

	a_rd_after_read: assert property (@(posedge clk_sys) disable iff (areset)
		rd_valid |-> $past(cmd_valid && cmd_ready &&
			(cmd_op inside {cmd_read_byte, cmd_read_status, cmd_read_size})));

endmodule

//--- disk/disk_request_seq.sv
`timescale 1ns/10ps

module disk_request_seq (
	input  logic                 clk_sys,
	input  logic                 areset,
	input  logic                 seq_start_rd,
	input  logic                 seq_start_wr,
	input  logic [1:0]           seq_slot,
	input  logic                 sd_ack,
	output disk_pkg::slot_mask_t sd_rd,
	output disk_pkg::slot_mask_t sd_wr,
	output logic                 seq_busy,
	output logic                 seq_done
);
	import disk_pkg::*;

	seq_state_e state;
	slot_mask_t slot_bit;

	assign slot_bit = slot_mask_t'(1 << seq_slot);
	assign seq_busy = state != seq_idle;

	// ==============================
	// Request FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			state    <= seq_idle;
			sd_rd    <= '0;
			sd_wr    <= '0;
			seq_done <= 1'b0;
		end else begin
			seq_done <= 1'b0;
			case (state)
				seq_idle: begin
					if (seq_start_rd) begin
						sd_rd <= slot_bit;
						state <= seq_wait_ack;
					end else if (seq_start_wr) begin
						sd_wr <= slot_bit;
						state <= seq_wait_ack;
					end
				end
				// Host owns the block until ack drops again
				seq_wait_ack: begin
					if (sd_ack) begin
						sd_rd <= '0;
						sd_wr <= '0;
						state <= seq_wait_release;
					end
				end
				seq_wait_release: begin
					if (!sd_ack) begin
						seq_done <= 1'b1;
						state    <= seq_idle;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (areset)
		!((|sd_rd) && (|sd_wr)));

	a_single_slot: assert property (@(posedge clk_sys) disable iff (areset)
		$onehot0(sd_rd) && $onehot0(sd_wr));

endmodule

//--- disk/sector_buffer.sv
`timescale 1ns/10ps

module sector_buffer (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  logic                   ptr_write,
	input  logic                   ptr_read,
	input  logic                   ptr_rewind,
	input  logic [7:0]             wr_byte,
	output logic [7:0]             rd_byte,
	input  disk_pkg::sector_addr_t sd_buff_addr,
	input  logic [7:0]             sd_buff_dout,
	input  logic                   sd_buff_wr,
	output logic [7:0]             sd_buff_din
);
	import disk_pkg::*;

	logic [7:0]   mem [SECTOR_BYTES];
	sector_addr_t ptr;

	// Controller byte pointer
	always_ff @(posedge clk_sys) begin
		if (areset || ptr_rewind)
			ptr <= '0;
		else if (ptr_write || ptr_read)
			ptr <= (ptr == sector_addr_t'(SECTOR_BYTES - 1)) ? '0 : ptr + 1'b1;
	end

	// ==============================
	// Controller port
	// ==============================
	always @(posedge clk_sys) begin
		if (ptr_write)
			mem[ptr] <= wr_byte;
		if (ptr_read)
			rd_byte <= mem[ptr];
	end

	// ==============================
	// Host port
	// ==============================
	always @(posedge clk_sys) begin
		if (sd_buff_wr)
			mem[sd_buff_addr] <= sd_buff_dout;
		sd_buff_din <= mem[sd_buff_addr];
	end

endmodule

//--- hdl/mouse_axis.sv
`timescale 1ns/10ps

module mouse_axis (
	input  logic                 clk_sys,
	input  logic                 areset,
	input  axis_pkg::mouse_pkt_t ps2_mouse,
	input  axis_pkg::axis_t      joya_x,
	input  axis_pkg::axis_t      joya_y,
	input  logic                 cpu_halt,
	output axis_pkg::axis_t      paddle_x,
	output axis_pkg::axis_t      paddle_y,
	output logic                 mouse_active
);
	import axis_pkg::*;

	mouse_pkt_t pkt_q;
	logic       stb_old;
	logic       stb_change;
	logic       joy_live;
	pos_t       pos_x;
	pos_t       pos_y;

	// 9-bit PS/2 delta limited to the step window
	function automatic pos_t clamp_step(input logic sign, input logic [7:0] delta);
		pos_t d;
		d = {sign, delta};
		if (d > MOUSE_STEP_MAX)
			return pos_t'(MOUSE_STEP_MAX);
		if (d < -MOUSE_STEP_MAX)
			return pos_t'(-MOUSE_STEP_MAX);
		return d;
	endfunction

	function automatic pos_t next_pos(input pos_t pos, input pos_t step);
		logic signed [9:0] sum;
		sum = pos + step;
		if (sum > AXIS_MAX)
			return pos_t'(AXIS_MAX);
		if (sum < AXIS_MIN)
			return pos_t'(AXIS_MIN);
		return pos_t'(sum);
	endfunction

	// Packet is registered once before the strobe compare
	always_ff @(posedge clk_sys) begin
		pkt_q   <= ps2_mouse;
		stb_old <= pkt_q.strobe;
	end

	assign stb_change = pkt_q.strobe != stb_old;
	assign joy_live   = (|joya_x) || (|joya_y) || cpu_halt;

	always_ff @(posedge clk_sys) begin
		if (areset || joy_live) begin
			mouse_active <= 1'b0;
			pos_x        <= '0;
			pos_y        <= '0;
		end else if (stb_change) begin
			mouse_active <= 1'b1;
			pos_x        <= next_pos(pos_x, clamp_step(pkt_q.x_sign, pkt_q.x_delta));
			pos_y        <= next_pos(pos_y, clamp_step(pkt_q.y_sign, pkt_q.y_delta));
		end
	end

	assign paddle_x = mouse_active ? axis_t'(pos_x) : joya_x;
	assign paddle_y = mouse_active ? axis_t'(pos_y) : joya_y;

endmodule

//--- hdl/atari_io_bridge.sv
`timescale 1ns/10ps

module atari_io_bridge (
	input  logic                   clk_sys,
	input  logic                   areset,
	// Controller command port
	input  logic                   cmd_valid,
	input  disk_pkg::disk_cmd_e    cmd_op,
	input  disk_pkg::drive_num_t   cmd_drive,
	input  disk_pkg::ctrl_word_t   cmd_data,
	output logic                   cmd_ready,
	output logic                   rd_valid,
	output disk_pkg::ctrl_word_t   rd_data,
	// Host block port
	output disk_pkg::lba_t         sd_lba,
	output disk_pkg::slot_mask_t   sd_rd,
	output disk_pkg::slot_mask_t   sd_wr,
	input  logic                   sd_ack,
	input  disk_pkg::sector_addr_t sd_buff_addr,
	input  logic [7:0]             sd_buff_dout,
	input  logic                   sd_buff_wr,
	output logic [7:0]             sd_buff_din,
	// Image mount
	input  disk_pkg::slot_mask_t   img_mounted,
	input  logic                   img_readonly,
	input  logic [1:0]             img_type,
	input  disk_pkg::img_size_t    img_size,
	// Mouse and paddles
	input  axis_pkg::mouse_pkt_t   ps2_mouse,
	input  axis_pkg::axis_t        joya_x,
	input  axis_pkg::axis_t        joya_y,
	input  logic                   cpu_halt,
	output axis_pkg::axis_t        paddle_x,
	output axis_pkg::axis_t        paddle_y,
	output logic                   mouse_active
);

	logic       seq_start_rd;
	logic       seq_start_wr;
	logic [1:0] seq_slot;
	logic       seq_busy;
	logic       seq_done;
	logic       ptr_write;
	logic       ptr_read;
	logic       ptr_rewind;
	logic [7:0] wr_byte;
	logic [7:0] rd_byte;

	// ==============================
	// Disk path
	// ==============================
	disk_ctrl_regs u_disk_ctrl_regs (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_drive    (cmd_drive),
		.cmd_data     (cmd_data),
		.cmd_ready    (cmd_ready),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.sd_lba       (sd_lba),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_type     (img_type),
		.img_size     (img_size),
		.seq_start_rd (seq_start_rd),
		.seq_start_wr (seq_start_wr),
		.seq_slot     (seq_slot),
		.seq_busy     (seq_busy),
		.seq_done     (seq_done),
		.ptr_write    (ptr_write),
		.ptr_read     (ptr_read),
		.ptr_rewind   (ptr_rewind),
		.wr_byte      (wr_byte),
		.rd_byte      (rd_byte)
	);

	disk_request_seq u_disk_request_seq (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.seq_start_rd (seq_start_rd),
		.seq_start_wr (seq_start_wr),
		.seq_slot     (seq_slot),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.seq_busy     (seq_busy),
		.seq_done     (seq_done)
	);

	sector_buffer u_sector_buffer (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.ptr_write    (ptr_write),
		.ptr_read     (ptr_read),
		.ptr_rewind   (ptr_rewind),
		.wr_byte      (wr_byte),
		.rd_byte      (rd_byte),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_buff_din  (sd_buff_din)
	);

	// ==============================
	// Analog axes
	// ==============================
	mouse_axis u_mouse_axis (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.ps2_mouse    (ps2_mouse),
		.joya_x       (joya_x),
		.joya_y       (joya_y),
		.cpu_halt     (cpu_halt),
		.paddle_x     (paddle_x),
		.paddle_y     (paddle_y),
		.mouse_active (mouse_active)
	);

endmodule

//--- tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==============================
// Reference model
// ==============================

// Drives 0, 1 and 4 own slots 0, 1 and 2
function automatic int slot_of_drive(input drive_num_t drv);
	case (drv)
		3'd1:    return 1;
		3'd4:    return 2;
		default: return 0;
	endcase
endfunction

function automatic ctrl_word_t expected_status(input logic done, input logic toggle,
		input int slot, input logic [1:0] typ, input logic ro);
	ctrl_word_t w;
	w      = '0;
	w[0]   = done;
	w[1]   = toggle;
	w[4:2] = (slot == 2) ? 3'd4 : 3'(slot);
	w[6:5] = typ;
	// Slot 2 is always reported read-only
	w[7]   = ro | (slot == 2);
	return w;
endfunction

// Sign and delta form a 9-bit two's complement step
function automatic int mouse_step(input logic sign, input logic [7:0] delta);
	int d;
	d = sign ? int'(delta) - 256 : int'(delta);
	if (d > MOUSE_STEP_MAX)
		return MOUSE_STEP_MAX;
	if (d < -MOUSE_STEP_MAX)
		return -MOUSE_STEP_MAX;
	return d;
endfunction

function automatic int next_mouse_pos(input int pos, input int step);
	int sum;
	sum = pos + step;
	if (sum > AXIS_MAX)
		return AXIS_MAX;
	if (sum < AXIS_MIN)
		return AXIS_MIN;
	return sum;
endfunction

// ==============================
// Compare tasks
// ==============================
task automatic check_word(input string name, input ctrl_word_t got, input ctrl_word_t exp);
	if (got !== exp) begin
		$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
		stop_run();
	end
endtask

task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
	if (got !== exp) begin
		$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
		stop_run();
	end
endtask

task automatic check_axis(input string name, input axis_t got, input axis_t exp);
	if (got !== exp) begin
		$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
		stop_run();
	end
endtask

`endif

//--- tb/tb_atari_io_bridge.sv
`timescale 1ns/10ps

module tb_atari_io_bridge;
	import disk_pkg::*;
	import axis_pkg::*;

	localparam int NUM_TESTS = 6;

	logic         clk_sys;
	logic         areset;
	logic         cmd_valid;
	disk_cmd_e    cmd_op;
	drive_num_t   cmd_drive;
	ctrl_word_t   cmd_data;
	logic         cmd_ready;
	logic         rd_valid;
	ctrl_word_t   rd_data;
	lba_t         sd_lba;
	slot_mask_t   sd_rd;
	slot_mask_t   sd_wr;
	logic         sd_ack;
	sector_addr_t sd_buff_addr;
	logic [7:0]   sd_buff_dout;
	logic         sd_buff_wr;
	logic [7:0]   sd_buff_din;
	slot_mask_t   img_mounted;
	logic         img_readonly;
	logic [1:0]   img_type;
	img_size_t    img_size;
	mouse_pkt_t   ps2_mouse;
	axis_t        joya_x;
	axis_t        joya_y;
	logic         cpu_halt;
	axis_t        paddle_x;
	axis_t        paddle_y;
	logic         mouse_active;

	logic [7:0]   sector_data [SECTOR_BYTES];
	ctrl_word_t   exp_rd [$];
	logic         rd_pending;
	int           ack_delay;
	logic         host_done;
	int           mount_count;
	int           mount_slot;
	logic [1:0]   mount_type;
	logic         mount_ro;
	int           pos_x;
	int           pos_y;

	atari_io_bridge u_atari_io_bridge (.*);

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic fail_with(input string msg);
		$display("ERROR: %s", msg);
		stop_run();
	endtask

	`include "tb_checks.svh"

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	initial begin
		repeat (NUM_TESTS * 2000) @(posedge clk_sys);
		fail_with("watchdog expired before the test sequence finished");
	end

	// Host answers each block request after ack_delay cycles
	initial begin
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!areset && (sd_rd != '0 || sd_wr != '0)) begin
				repeat (ack_delay) @(posedge clk_sys);
				#2;
				sd_ack = 1'b1;
				do @(negedge clk_sys); while (sd_rd != '0 || sd_wr != '0);
				repeat (ack_delay) @(posedge clk_sys);
				#2;
				sd_ack    = 1'b0;
				host_done = 1'b1;
			end
		end
	end

	// Read-back monitor, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (areset) begin
			rd_pending = 1'b0;
		end else begin
			if (rd_valid !== rd_pending)
				fail_with("rd_valid did not pulse exactly one cycle after a read command");
			else if (rd_valid === 1'b1 && exp_rd.size() == 0)
				fail_with("rd_valid pulsed with no read-back expected");
			else if (rd_valid === 1'b1)
				check_word("rd_data", rd_data, exp_rd.pop_front());
			rd_pending = cmd_valid && cmd_ready && (cmd_op == cmd_read_byte ||
				cmd_op == cmd_read_status || cmd_op == cmd_read_size);
		end
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// Called 2 ns after a rising edge, returns 2 ns after acceptance
	task automatic send_cmd(input disk_cmd_e op, input drive_num_t drv, input ctrl_word_t data);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_drive = drv;
		cmd_data  = data;
		do @(negedge clk_sys); while (cmd_ready !== 1'b1);
		@(posedge clk_sys);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic hold_until_release();
		while (!host_done) begin
			@(negedge clk_sys);
			if (cmd_ready !== 1'b0)
				fail_with("cmd_ready rose while a block request was still open");
		end
	endtask

	task automatic send_packet(input int dx, input int dy);
		mouse_pkt_t pkt;
		logic [8:0] x9;
		logic [8:0] y9;
		pkt         = ps2_mouse;
		x9          = 9'(dx);
		y9          = 9'(dy);
		pkt.strobe  = ~pkt.strobe;
		pkt.x_sign  = x9[8];
		pkt.x_delta = x9[7:0];
		pkt.y_sign  = y9[8];
		pkt.y_delta = y9[7:0];
		pkt.buttons = 2'($urandom);
		ps2_mouse   = pkt;
		pos_x       = next_mouse_pos(pos_x, mouse_step(pkt.x_sign, pkt.x_delta));
		pos_y       = next_mouse_pos(pos_y, mouse_step(pkt.y_sign, pkt.y_delta));
		repeat (2) @(posedge clk_sys);
		#2;
		if (mouse_active !== 1'b1)
			fail_with("mouse_active not set after a mouse packet");
		check_axis("paddle_x", paddle_x, axis_t'(pos_x));
		check_axis("paddle_y", paddle_y, axis_t'(pos_y));
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic test_buffer();
		ctrl_word_t w;
		send_cmd(cmd_rewind, 3'd0, '0);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			w              = $urandom;
			sector_data[i] = w[7:0];
			send_cmd(cmd_write_byte, 3'd0, w);
		end
		send_cmd(cmd_rewind, 3'd0, '0);
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			exp_rd.push_back(ctrl_word_t'(sector_data[i]));
			send_cmd(cmd_read_byte, 3'd0, '0);
		end
		// Host side sees the same sector
		for (int i = 0; i < SECTOR_BYTES; i++) begin
			sd_buff_addr = sector_addr_t'(i);
			@(posedge clk_sys);
			#2;
			check_word("sd_buff_din", ctrl_word_t'(sd_buff_din), ctrl_word_t'(sector_data[i]));
		end
		sd_buff_addr = '0;
	endtask

	task automatic test_mount();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			mount_slot   = s;
			mount_type   = 2'($urandom);
			mount_ro     = 1'($urandom);
			img_type     = mount_type;
			img_readonly = mount_ro;
			img_size     = $urandom;
			img_mounted  = slot_mask_t'(1 << s);
			repeat (3) @(posedge clk_sys);
			#2;
			img_mounted = '0;
			repeat (3) @(posedge clk_sys);
			#2;
			mount_count++;
			exp_rd.push_back(expected_status(1'b0, mount_count[0], s, mount_type, mount_ro));
			send_cmd(cmd_read_status, 3'd0, '0);
			exp_rd.push_back(img_size);
			send_cmd(cmd_read_size, 3'd0, '0);
		end
	endtask

	task automatic test_block(input disk_cmd_e op);
		drive_num_t drives [3];
		lba_t       lba;
		slot_mask_t mask;
		drives = '{3'd0, 3'd1, 3'd4};
		foreach (drives[i]) begin
			lba       = $urandom;
			mask      = slot_mask_t'(1 << slot_of_drive(drives[i]));
			ack_delay = $urandom_range(1, 8);
			host_done = 1'b0;
			send_cmd(cmd_set_lba, drives[i], lba);
			send_cmd(op, drives[i], '0);
			check_mask("sd_rd", sd_rd, (op == cmd_block_read) ? mask : slot_mask_t'(0));
			check_mask("sd_wr", sd_wr, (op == cmd_block_write) ? mask : slot_mask_t'(0));
			check_word("sd_lba", sd_lba, lba);
			if (op == cmd_block_write) begin
				// Status read waits behind the open request
				exp_rd.push_back(expected_status(1'b0, mount_count[0], mount_slot,
					mount_type, mount_ro));
				fork
					send_cmd(cmd_read_status, 3'd0, '0);
					hold_until_release();
				join
			end else begin
				hold_until_release();
				repeat (2) @(posedge clk_sys);
				#2;
			end
			exp_rd.push_back(expected_status(1'b1, mount_count[0], mount_slot,
				mount_type, mount_ro));
			send_cmd(cmd_read_status, 3'd0, '0);
		end
	endtask

	task automatic test_mouse();
		pos_x = 0;
		pos_y = 0;
		for (int k = 0; k < 60; k++) begin
			if (k < 20)
				send_packet($urandom_range(0, 40), -int'($urandom_range(0, 40)));
			else if (k < 40)
				send_packet(-int'($urandom_range(0, 40)), $urandom_range(0, 40));
			else
				send_packet(int'($urandom_range(0, 511)) - 256, int'($urandom_range(0, 511)) - 256);
		end
	endtask

	task automatic test_source_return();
		for (int k = 0; k < 4; k++) begin
			joya_x = 8'($urandom_range(1, 255));
			joya_y = 8'($urandom);
			@(posedge clk_sys);
			#2;
			if (mouse_active !== 1'b0)
				fail_with("joystick motion did not clear mouse_active");
			check_axis("paddle_x", paddle_x, joya_x);
			check_axis("paddle_y", paddle_y, joya_y);
		end
		joya_x = '0;
		joya_y = '0;
		pos_x  = 0;
		pos_y  = 0;
		send_packet(5, -3);
		cpu_halt = 1'b1;
		@(posedge clk_sys);
		#2;
		if (mouse_active !== 1'b0)
			fail_with("cpu_halt did not clear mouse_active");
		check_axis("paddle_x", paddle_x, joya_x);
		check_axis("paddle_y", paddle_y, joya_y);
		cpu_halt = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hceb7df9b));
		areset       = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = cmd_set_lba;
		cmd_drive    = '0;
		cmd_data     = '0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_type     = '0;
		img_size     = '0;
		ps2_mouse    = '0;
		joya_x       = '0;
		joya_y       = '0;
		cpu_halt     = 1'b0;
		ack_delay    = 1;
		host_done    = 1'b0;
		mount_count  = 0;
		repeat (8) @(posedge clk_sys);
		#2;
		areset = 1'b0;
		if (cmd_ready !== 1'b1 || rd_valid !== 1'b0 || mouse_active !== 1'b0)
			fail_with("outputs not in their reset state");
		check_mask("sd_rd", sd_rd, '0);
		check_mask("sd_wr", sd_wr, '0);

		test_buffer();
		test_mount();
		test_block(cmd_block_read);
		test_block(cmd_block_write);
		test_mouse();
		test_source_return();

		repeat (4) @(posedge clk_sys);
		if (exp_rd.size() != 0) begin
			fail_with("expected read-back data never arrived");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

//--- atari_io_bridge.f
+incdir+tb
common/disk_pkg.sv
common/axis_pkg.sv
disk/disk_ctrl_regs.sv
disk/disk_request_seq.sv
disk/sector_buffer.sv
hdl/mouse_axis.sv
hdl/atari_io_bridge.sv
tb/tb_atari_io_bridge.sv

//--- Bender.yml
package:
  name: atari_io_bridge

sources:
  - common/disk_pkg.sv
  - common/axis_pkg.sv
  - disk/disk_ctrl_regs.sv
  - disk/disk_request_seq.sv
  - disk/sector_buffer.sv
  - hdl/mouse_axis.sv
  - hdl/atari_io_bridge.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_atari_io_bridge.sv
